/* marble_test.f */
marble_pkg.sv
gmii_to_rgmii.sv
beat_fifo.sv
frame_echo.sv
spi_config.sv
led_heartbeat.sv
marble_base.sv
marble_top.sv
marble_checker.sv
marble_tb.sv

/* Bender.yml */
package:
  name: marble_test

sources:
  - marble_pkg.sv
  - gmii_to_rgmii.sv
  - beat_fifo.sv
  - frame_echo.sv
  - spi_config.sv
  - led_heartbeat.sv
  - marble_base.sv
  - marble_top.sv
  - target: test
    files:
      - marble_checker.sv
      - marble_tb.sv

/* marble_tb.sv */
// Marble test build testbench
module marble_tb;

	localparam int SPI_HALF = 6;
	localparam int WAIT_LIMIT = 6000;

	logic       tx_clk;
	logic       rst_n;
	logic [3:0] rgmii_txd;
	logic       rgmii_tx_ctrl;
	logic       rgmii_tx_clk;
	logic [3:0] rgmii_rxd;
	logic       rgmii_rx_ctrl;
	logic       sclk;
	logic       csb;
	logic       mosi;
	logic       miso;
	logic       vcxo_en;
	logic [7:0] led;

	int unsigned seed;
	bit          aborted;
	int          echoes;
	int          frames_before;
	int          hb_wait;
	logic [7:0]  rd;
	logic [7:0]  val;

	marble_top UUT (
		.tx_clk(tx_clk), .rst_n(rst_n),
		.RGMII_TXD(rgmii_txd), .RGMII_TX_CTRL(rgmii_tx_ctrl), .RGMII_TX_CLK(rgmii_tx_clk),
		.RGMII_RXD(rgmii_rxd), .RGMII_RX_CTRL(rgmii_rx_ctrl),
		.SCLK(sclk), .CSB(csb), .MOSI(mosi), .MISO(miso),
		.VCXO_EN(vcxo_en), .LED(led)
	);

	marble_checker chk (
		.tx_clk(tx_clk), .rgmii_txd(rgmii_txd), .rgmii_tx_ctl(rgmii_tx_ctrl),
		.rgmii_tx_clk(rgmii_tx_clk)
	);

	always #2 tx_clk = ~tx_clk;

	// Low nibble and en after the falling edge, high nibble and en^er after the rising edge
	task automatic put_beat(input logic [7:0] data, input logic en, input logic er);
		@(negedge tx_clk);
		rgmii_rxd <= data[3:0];
		rgmii_rx_ctrl <= en;
		@(posedge tx_clk);
		rgmii_rxd <= data[7:4];
		rgmii_rx_ctrl <= en ^ er;
	endtask

	task automatic idle_gap(input int n);
		repeat (n) put_beat(8'h00, 1'b0, 1'b0);
	endtask

	task automatic send_frame(input int len, input bit with_err, input bit echoed);
		logic [7:0] data;
		bit         er;
		bit         bad;
		bad = 1'b0;
		for (int i = 0; i < len; i++) begin
			data = 8'($urandom());
			// Random error beats plus one forced in the middle
			er = with_err && (($urandom_range(3, 0) == 0) || (i == len / 2));
			bad = bad || er;
			put_beat(data, 1'b1, er);
			if (echoed) begin
				chk.expect_byte(data);
			end
		end
		@(negedge tx_clk);
		rgmii_rxd <= 4'h0;
		rgmii_rx_ctrl <= 1'b0;
		// Frame end in checker cycles
		if (echoed) begin
			chk.expect_frame(len, bad, chk.cyc);
		end
	endtask

	// SPI mode 0 with MOSI set while SCLK is low and MISO sampled before each rise
	task automatic shift_spi_word(input logic [15:0] word, output logic [7:0] data);
		data = 8'h00;
		@(negedge tx_clk);
		csb <= 1'b0;
		repeat (SPI_HALF) @(negedge tx_clk);
		for (int i = 15; i >= 0; i--) begin
			mosi <= word[i];
			repeat (SPI_HALF) @(negedge tx_clk);
			if (i < 8) begin
				data[i] = miso;
			end
			sclk <= 1'b1;
			repeat (SPI_HALF) @(negedge tx_clk);
			sclk <= 1'b0;
		end
		repeat (SPI_HALF) @(negedge tx_clk);
		csb <= 1'b1;
		repeat (2 * SPI_HALF) @(negedge tx_clk);
	endtask

	task automatic write_reg(input logic [6:0] addr, input logic [7:0] data);
		logic [7:0] ignored;
		shift_spi_word({1'b0, addr, data}, ignored);
	endtask

	task automatic read_reg(input logic [6:0] addr, output logic [7:0] data);
		shift_spi_word({1'b1, addr, 8'h00}, data);
	endtask

	// Poll until the echo backlog is at most limit frames
	task automatic wait_pending(input int limit, input string what);
		int n;
		n = 0;
		while (!aborted && chk.pending() > limit) begin
			@(negedge tx_clk);
			n++;
			if (n > WAIT_LIMIT) begin
				chk.report_failure($sformatf("timeout waiting for %s", what));
				aborted = 1'b1;
			end
		end
	endtask

	initial begin
		tx_clk = 1'b0;
		rst_n = 1'b0;
		rgmii_rxd = 4'h0;
		rgmii_rx_ctrl = 1'b0;
		sclk = 1'b0;
		csb = 1'b1;
		mosi = 1'b0;
		aborted = 1'b0;
		echoes = 0;
		seed = 32'hc0f0_b451;
		void'($urandom(seed));
		repeat (3) @(negedge tx_clk);
		rst_n <= 1'b1;

		chk.start_test("reset");
		repeat (2) @(negedge tx_clk);
		chk.check_value("vcxo_en", 1, vcxo_en);
		chk.check_value("led count", 0, led[7:4]);
		chk.check_value("led spare bits", 0, led[3:1]);
		chk.check_value("led heartbeat after reset", 0, led[0]);
		chk.check_value("miso", 0, miso);
		repeat (50) @(negedge tx_clk);
		chk.check_value("frames after reset", 0, chk.frames_seen);
		// Heartbeat rises when the counter first reaches 2**HB_BITS
		hb_wait = 52;
		while (led[0] !== 1'b1 && hb_wait < (2 << marble_pkg::HB_BITS)) begin
			@(negedge tx_clk);
			hb_wait++;
		end
		chk.check_value("heartbeat rise cycle", 1 << marble_pkg::HB_BITS, hb_wait);
		chk.end_test();

		chk.start_test("echo");
		for (int f = 0; f < 20; f++) begin
			// Backlog stays well inside the descriptor FIFO
			wait_pending(8, "echo backlog");
			send_frame($urandom_range(64, 8), 1'b0, 1'b1);
			idle_gap($urandom_range(marble_pkg::IFG_CYCLES + 20, marble_pkg::IFG_CYCLES));
		end
		wait_pending(0, "echoes of random frames");
		echoes += 20;
		chk.end_test();

		chk.start_test("error frames");
		for (int f = 0; f < 3; f++) begin
			send_frame($urandom_range(64, 8), 1'b1, 1'b1);
			idle_gap($urandom_range(marble_pkg::IFG_CYCLES + 20, marble_pkg::IFG_CYCLES));
		end
		wait_pending(0, "echoes of error frames");
		echoes += 3;
		chk.end_test();

		chk.start_test("spi");
		val = 8'($urandom_range(15, 0) | 1);
		write_reg(marble_pkg::REG_EXT_CONFIG, val);
		read_reg(marble_pkg::REG_EXT_CONFIG, rd);
		chk.check_value("ext_config readback", val, rd);
		chk.check_value("vcxo_en after random config", !val[1], vcxo_en);
		write_reg(marble_pkg::REG_EXT_CONFIG, 8'h03);
		chk.check_value("vcxo_en with bit 1 set", 0, vcxo_en);
		val = 8'($urandom());
		write_reg(marble_pkg::REG_LED_VALUE, val);
		read_reg(marble_pkg::REG_LED_VALUE, rd);
		chk.check_value("led_value readback", val, rd);
		val = 8'($urandom());
		write_reg(marble_pkg::REG_LED_OVERRIDE, val);
		read_reg(marble_pkg::REG_LED_OVERRIDE, rd);
		chk.check_value("led_override readback", {7'b0000000, val[0]}, rd);
		write_reg(marble_pkg::REG_LED_OVERRIDE, 8'h00);
		// With echo off the frame must not come back
		write_reg(marble_pkg::REG_EXT_CONFIG, 8'h00);
		frames_before = chk.frames_seen;
		send_frame($urandom_range(64, 8), 1'b0, 1'b0);
		idle_gap(200);
		chk.check_value("frames with echo off", frames_before, chk.frames_seen);
		write_reg(marble_pkg::REG_EXT_CONFIG, {4'h0, marble_pkg::CFG_DEFAULT});
		chk.check_value("vcxo_en restored", 1, vcxo_en);
		chk.end_test();

		chk.start_test("led");
		val = 8'($urandom_range(5, 1));
		for (int f = 0; f < val; f++) begin
			send_frame($urandom_range(64, 8), 1'b0, 1'b1);
			idle_gap($urandom_range(marble_pkg::IFG_CYCLES + 20, marble_pkg::IFG_CYCLES));
		end
		wait_pending(0, "echoes for the LED count");
		echoes += val;
		repeat (4) @(negedge tx_clk);
		chk.check_value("led echo count", echoes % 16, led[7:4]);
		chk.check_value("led spare bits", 0, led[3:1]);
		val = 8'($urandom());
		write_reg(marble_pkg::REG_LED_VALUE, val);
		write_reg(marble_pkg::REG_LED_OVERRIDE, 8'h01);
		chk.check_value("led override value", val, led);
		write_reg(marble_pkg::REG_LED_OVERRIDE, 8'h00);
		chk.end_test();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			chk.test_count, chk.failed_tests, chk.check_count, chk.error_count);
		if (aborted || chk.error_count != 0) begin
			$display("RESULT: FAIL");
		end else begin
			$display("RESULT: PASS");
		end
		$finish;
	end

endmodule

/* marble_checker.sv */
// RGMII transmit monitor and scoreboard
module marble_checker (
	input logic       tx_clk,
	input logic [3:0] rgmii_txd,
	input logic       rgmii_tx_ctl,
	input logic       rgmii_tx_clk
);

	// Expected frames with the bytes of all frames in one flat queue
	logic [7:0] exp_data_q[$];
	int         exp_len_q[$];
	bit         exp_bad_q[$];
	int         exp_end_q[$];
	// Frame being decoded
	logic [7:0] rx_q[$];
	int         er_beats;
	int         start_cyc;
	bit         in_frame = 1'b0;
	logic [3:0] lo_nib;
	logic [3:0] hi_nib;
	logic       ctl_first;
	logic       ctl_second;
	logic       clk_high;
	// Run bookkeeping
	int    cyc = 0;
	int    frames_seen = 0;
	int    check_count = 0;
	int    error_count = 0;
	int    test_errors = 0;
	int    test_count = 0;
	int    failed_tests = 0;
	string current_test = "none";

	task automatic expect_byte(input logic [7:0] data);
		exp_data_q.push_back(data);
	endtask

	task automatic expect_frame(input int len, input bit bad, input int end_cyc);
		exp_len_q.push_back(len);
		exp_bad_q.push_back(bad);
		exp_end_q.push_back(end_cyc);
	endtask

	// Frames still owed by the DUT
	function automatic int pending();
		return exp_len_q.size();
	endfunction

	task automatic start_test(input string name);
		current_test = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		test_count++;
		if (test_errors == 0) begin
			$display("test %s: passed", current_test);
		end else begin
			failed_tests++;
			$display("test %s: failed with %0d errors", current_test, test_errors);
		end
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			test_errors++;
			$display("[ERROR] test %s, %s: expected %0h, actual %0h",
				current_test, what, expected, actual);
		end
	endtask

	task automatic report_failure(input string what);
		error_count++;
		test_errors++;
		$display("test %s: %s", current_test, what);
	endtask

	task automatic compare_frame();
		int         exp_n;
		bit         exp_bad;
		int         exp_end;
		logic [7:0] exp_byte;
		frames_seen++;
		if (exp_len_q.size() == 0) begin
			report_failure($sformatf("unexpected transmit frame of %0d bytes", rx_q.size()));
		end else begin
			exp_n = exp_len_q.pop_front();
			exp_bad = exp_bad_q.pop_front();
			exp_end = exp_end_q.pop_front();
			check_value($sformatf("frame %0d length", frames_seen), exp_n, rx_q.size());
			for (int i = 0; i < exp_n; i++) begin
				exp_byte = exp_data_q.pop_front();
				if (i < rx_q.size()) begin
					check_value($sformatf("frame %0d byte %0d", frames_seen, i),
						exp_byte, rx_q[i]);
				end
			end
			// A bad frame comes back with er on every beat
			check_value($sformatf("frame %0d er beats", frames_seen),
				exp_bad ? exp_n : 0, er_beats);
			if (start_cyc - exp_end < marble_pkg::IFG_CYCLES + 3) begin
				report_failure($sformatf("frame %0d echo started %0d cycles after its end",
					frames_seen, start_cyc - exp_end));
			end
		end
	endtask

	// Beat assembly where the second ctl half is en xor er
	task automatic take_beat();
		if (ctl_first === 1'b1) begin
			if (!in_frame) begin
				in_frame = 1'b1;
				start_cyc = cyc;
				rx_q.delete();
				er_beats = 0;
			end
			rx_q.push_back({hi_nib, lo_nib});
			if (ctl_second !== ctl_first) begin
				er_beats++;
			end
		end else if (in_frame) begin
			in_frame = 1'b0;
			compare_frame();
		end
	endtask

	always @(posedge tx_clk) begin
		cyc <= cyc + 1;
	end

	// Each nibble sampled mid-phase
	always begin
		@(posedge tx_clk);
		#1;
		lo_nib = rgmii_txd;
		ctl_first = rgmii_tx_ctl;
		clk_high = rgmii_tx_clk;
		@(negedge tx_clk);
		#1;
		hi_nib = rgmii_txd;
		ctl_second = rgmii_tx_ctl;
		// Forwarded clock follows tx_clk in both phases
		if (clk_high !== 1'b1 || rgmii_tx_clk !== 1'b0) begin
			report_failure("RGMII_TX_CLK does not follow tx_clk");
		end
		take_beat();
	end

endmodule

/* marble_top.sv */
// Marble board test top
module marble_top (
	input  logic       tx_clk,
	input  logic       rst_n,
	// RGMII transmit
	output logic [3:0] RGMII_TXD,
	output logic       RGMII_TX_CTRL,
	output logic       RGMII_TX_CLK,
	// RGMII receive, same clock source as tx_clk
	input  logic [3:0] RGMII_RXD,
	input  logic       RGMII_RX_CTRL,
	// SPI from the microcontroller
	input  logic       SCLK,
	input  logic       CSB,
	input  logic       MOSI,
	output logic       MISO,
	output logic       VCXO_EN,
	output logic [7:0] LED
);

	marble_pkg::gmii_beat_t rx_beat;
	marble_pkg::gmii_beat_t tx_beat;

	// Double-data-rate conversion
	gmii_to_rgmii gmii_to_rgmii_i (
		.tx_clk(tx_clk), .rst_n(rst_n),
		.tx_beat(tx_beat), .rx_beat(rx_beat),
		.rgmii_txd(RGMII_TXD), .rgmii_tx_ctl(RGMII_TX_CTRL),
		.rgmii_tx_clk(RGMII_TX_CLK),
		.rgmii_rxd(RGMII_RXD), .rgmii_rx_ctl(RGMII_RX_CTRL)
	);

	// Portable logic behind the GMII port
	marble_base base (
		.tx_clk(tx_clk), .rst_n(rst_n),
		.rx_beat(rx_beat), .tx_beat(tx_beat),
		.sclk(SCLK), .csb(CSB), .mosi(MOSI), .miso(MISO),
		.vcxo_en(VCXO_EN), .led(LED)
	);

endmodule

/* marble_base.sv */
// Portable Marble test base
module marble_base (
	input  logic                   tx_clk,
	input  logic                   rst_n,
	input  marble_pkg::gmii_beat_t rx_beat,
	output marble_pkg::gmii_beat_t tx_beat,
	input  logic                   sclk,
	input  logic                   csb,
	input  logic                   mosi,
	output logic                   miso,
	output logic                   vcxo_en,
	output logic [7:0]             led
);

	marble_pkg::cfg_t cfg;
	logic             echo_done;

	// Raw frame loopback, gated by ext_config bit 0
	frame_echo echo (
		.tx_clk(tx_clk),
		.rst_n(rst_n),
		.enable(cfg.ext_config[0]),
		.rx_beat(rx_beat),
		.tx_beat(tx_beat),
		.echo_done(echo_done)
	);

	// Microcontroller register access
	spi_config spi (
		.tx_clk(tx_clk),
		.rst_n(rst_n),
		.sclk(sclk),
		.csb(csb),
		.mosi(mosi),
		.miso(miso),
		.cfg(cfg)
	);

	led_heartbeat leds (
		.tx_clk(tx_clk),
		.rst_n(rst_n),
		.cfg(cfg),
		.echo_done(echo_done),
		.led(led)
	);

	// Bit 1 lets the host switch the VCXO off
	assign vcxo_en = ~cfg.ext_config[1];

endmodule

/* led_heartbeat.sv */
// LED heartbeat and source select
module led_heartbeat (
	input  logic             tx_clk,
	input  logic             rst_n,
	input  marble_pkg::cfg_t cfg,
	input  logic             echo_done,
	output logic [7:0]       led
);

	// Free-running counter, heartbeat on its top bit
	logic [marble_pkg::HB_BITS:0] hb_cnt;
	logic [3:0]                   echo_cnt;

	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			hb_cnt <= '0;
			echo_cnt <= 4'h0;
		end else begin
			hb_cnt <= hb_cnt + 1'b1;
			// Wraps modulo 16
			if (echo_done) begin
				echo_cnt <= echo_cnt + 1'b1;
			end
		end
	end

	// Override shows the SPI value as is
	assign led = cfg.led_override ? cfg.led_value :
		{echo_cnt, 3'b000, hb_cnt[marble_pkg::HB_BITS]};

endmodule

/* spi_config.sv */
// SPI slave and configuration registers
module spi_config (
	input  logic             tx_clk,
	input  logic             rst_n,
	input  logic             sclk,
	input  logic             csb,
	input  logic             mosi,
	output logic             miso,
	output marble_pkg::cfg_t cfg
);

	// Two-flop synchronizers plus edge history
	logic [1:0] sclk_sync;
	logic [1:0] csb_sync;
	logic [1:0] mosi_sync;
	logic       sclk_d;
	logic       csb_d;
	logic       sclk_rise;
	logic       sclk_fall;
	logic       csb_rise;
	// Command shift register and bit count
	logic [15:0]      shift;
	logic [4:0]       bit_cnt;
	logic [7:0]       rd_shift;
	logic [7:0]       rd_value;
	marble_pkg::cfg_t cfg_q;

	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			sclk_sync <= 2'b00;
			csb_sync <= 2'b11;
			sclk_d <= 1'b0;
			csb_d <= 1'b1;
		end else begin
			sclk_sync <= {sclk_sync[0], sclk};
			csb_sync <= {csb_sync[0], csb};
			sclk_d <= sclk_sync[1];
			csb_d <= csb_sync[1];
		end
	end

	always_ff @(posedge tx_clk) begin
		mosi_sync <= {mosi_sync[0], mosi};
	end

	assign sclk_rise = sclk_sync[1] && !sclk_d;
	assign sclk_fall = !sclk_sync[1] && sclk_d;
	assign csb_rise = csb_sync[1] && !csb_d;

	// Readback on the address held in the low byte after 8 bits
	always_comb begin
		case (shift[6:0])
			marble_pkg::REG_EXT_CONFIG:   rd_value = {4'b0000, cfg_q.ext_config};
			marble_pkg::REG_LED_VALUE:    rd_value = cfg_q.led_value;
			marble_pkg::REG_LED_OVERRIDE: rd_value = {7'b0000000, cfg_q.led_override};
			default:                      rd_value = 8'h00;
		endcase
	end

	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			shift <= '0;
			bit_cnt <= '0;
			rd_shift <= '0;
		end else if (csb_sync[1]) begin
			bit_cnt <= '0;
			rd_shift <= '0;
		end else begin
			if (sclk_rise) begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt < 5'd16) begin
					shift <= {shift[14:0], mosi_sync[1]};
				end
			end
			// Read data launched after the 8th falling edge, MSB first
			if (sclk_fall) begin
				if (bit_cnt == 5'd8 && shift[7]) begin
					rd_shift <= rd_value;
				end else begin
					rd_shift <= {rd_shift[6:0], 1'b0};
				end
			end
		end
	end

	// Write commits on CSB release, full 16-bit frames only
	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			cfg_q <= '{ext_config: marble_pkg::CFG_DEFAULT, led_value: 8'h00, led_override: 1'b0};
		end else if (csb_rise && bit_cnt == 5'd16 && !shift[15]) begin
			case (shift[14:8])
				marble_pkg::REG_EXT_CONFIG:   cfg_q.ext_config <= shift[3:0];
				marble_pkg::REG_LED_VALUE:    cfg_q.led_value <= shift[7:0];
				marble_pkg::REG_LED_OVERRIDE: cfg_q.led_override <= shift[0];
				default:                      ;
			endcase
		end
	end

	assign miso = rd_shift[7];
	assign cfg = cfg_q;

	// Master clocks at most one 16-bit word per select
	spi_word_len: assert property (@(posedge tx_clk) disable iff (!rst_n)
		bit_cnt <= 5'd16)
		else $error("more than 16 SCLK edges in one transaction");

endmodule

/* frame_echo.sv */
// Ethernet frame store and echo
module frame_echo (
	input  logic                   tx_clk,
	input  logic                   rst_n,
	input  logic                   enable,
	input  marble_pkg::gmii_beat_t rx_beat,
	output marble_pkg::gmii_beat_t tx_beat,
	output logic                   echo_done
);

	localparam int LEN_W = marble_pkg::LEN_BITS;
	localparam int GAP_W = $clog2(marble_pkg::IFG_CYCLES + 1);
	localparam logic [GAP_W-1:0] GAP_DONE = GAP_W'(marble_pkg::IFG_CYCLES);

	// Receive side
	logic             rx_en_d;
	logic             rx_start;
	logic             rx_keep;
	logic             storing;
	logic             len_max;
	logic [LEN_W-1:0] rx_len;
	logic             rx_bad;
	// FIFO ports
	logic                    data_push;
	logic                    data_pop;
	logic [7:0]              data_dout;
	logic                    data_empty;
	logic                    data_full;
	logic                    info_push;
	logic                    info_pop;
	marble_pkg::frame_info_t info_din;
	marble_pkg::frame_info_t info_dout;
	logic                    info_empty;
	logic                    info_full;
	// Transmit side
	logic [GAP_W-1:0] gap_cnt;
	logic             tx_start;
	logic             tx_active;
	logic [LEN_W-1:0] tx_left;
	logic             tx_bad;
	logic [7:0]       tx_data_q;
	logic             tx_en_q;
	logic             tx_er_q;
	// Echo length bookkeeping for the length check
	logic [LEN_W-1:0] tx_frame_len;
	logic [LEN_W:0]   tx_run;

	beat_fifo #(.payload_t(logic [7:0]), .DEPTH(marble_pkg::DATA_DEPTH)) data_fifo (
		.tx_clk(tx_clk), .rst_n(rst_n),
		.push(data_push), .din(rx_beat.data),
		.pop(data_pop), .dout(data_dout),
		.empty(data_empty), .full(data_full)
	);

	beat_fifo #(.payload_t(marble_pkg::frame_info_t), .DEPTH(marble_pkg::INFO_DEPTH)) info_fifo (
		.tx_clk(tx_clk), .rst_n(rst_n),
		.push(info_push), .din(info_din),
		.pop(info_pop), .dout(info_dout),
		.empty(info_empty), .full(info_full)
	);

	// Frame accepted only if both FIFOs have room at its first beat
	assign rx_start = rx_beat.en && !rx_en_d;
	assign rx_keep = rx_start ? (enable && !info_full && !data_full) : storing;
	assign len_max = !rx_start && (&rx_len);
	assign data_push = rx_beat.en && rx_keep && !data_full && !len_max;
	// Descriptor goes in on the falling edge of dv
	assign info_push = !rx_beat.en && rx_en_d && storing;
	assign info_din = '{len: rx_len, bad: rx_bad};

	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			rx_en_d <= 1'b0;
			storing <= 1'b0;
			rx_len <= '0;
			rx_bad <= 1'b0;
		end else begin
			rx_en_d <= rx_beat.en;
			storing <= rx_beat.en && rx_keep;
			if (rx_start) begin
				rx_len <= LEN_W'(data_push);
				rx_bad <= rx_beat.er;
			end else if (rx_beat.en) begin
				rx_len <= rx_len + LEN_W'(data_push);
				// A byte that finds no room spoils the stored copy
				rx_bad <= rx_bad || rx_beat.er || !data_push;
			end
		end
	end

	// Start needs a descriptor and a full gap on both sides
	assign tx_start = !tx_active && !tx_en_q && !info_empty && (gap_cnt == GAP_DONE);
	assign info_pop = tx_start;
	assign data_pop = tx_active && !data_empty;

	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			gap_cnt <= '0;
			tx_active <= 1'b0;
			tx_left <= '0;
			tx_bad <= 1'b0;
			tx_frame_len <= '0;
			tx_en_q <= 1'b0;
			tx_er_q <= 1'b0;
			tx_run <= '0;
		end else begin
			// Idle count restarts on any rx or tx activity
			if (rx_beat.en || tx_active || tx_en_q) begin
				gap_cnt <= '0;
			end else if (gap_cnt != GAP_DONE) begin
				gap_cnt <= gap_cnt + 1'b1;
			end
			if (tx_start) begin
				tx_active <= 1'b1;
				tx_left <= info_dout.len;
				tx_bad <= info_dout.bad;
				tx_frame_len <= info_dout.len;
			end else if (tx_active) begin
				tx_left <= tx_left - 1'b1;
				if (tx_left == LEN_W'(1)) begin
					tx_active <= 1'b0;
				end
			end
			tx_en_q <= tx_active;
			// Whole echo carries the error flag
			tx_er_q <= tx_active && tx_bad;
			tx_run <= tx_en_q ? tx_run + 1'b1 : '0;
		end
	end

	always_ff @(posedge tx_clk) begin
		tx_data_q <= data_dout;
	end

	assign tx_beat = '{data: tx_data_q, en: tx_en_q, er: tx_er_q};
	// Last beat on the wire
	assign echo_done = tx_en_q && !tx_active;

	// Echo never runs past its descriptor length
	echo_len_bound: assert property (@(posedge tx_clk) disable iff (!rst_n)
		tx_en_q |-> (tx_run < {1'b0, tx_frame_len}))
		else $error("echo longer than descriptor");

endmodule

/* beat_fifo.sv */
// Synchronous first-word-fall-through FIFO
module beat_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH = 16
) (
	input  logic     tx_clk,
	input  logic     rst_n,
	input  logic     push,
	input  payload_t din,
	input  logic     pop,
	output payload_t dout,
	output logic     empty,
	output logic     full
);

	localparam int AW = $clog2(DEPTH);

	payload_t mem [DEPTH];
	// Extra MSB tells full from empty
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;

	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push && !full) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop && !empty) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge tx_clk) begin
		if (push && !full) begin
			mem[wr_ptr[AW-1:0]] <= din;
		end
	end

	// Head entry is visible without a pop
	assign dout = mem[rd_ptr[AW-1:0]];
	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	// Callers check the flags
	no_push_full: assert property (@(posedge tx_clk) disable iff (!rst_n)
		!(push && full))
		else $error("push while full");
	no_pop_empty: assert property (@(posedge tx_clk) disable iff (!rst_n)
		!(pop && empty))
		else $error("pop while empty");

endmodule

/* gmii_to_rgmii.sv */
// RGMII to GMII conversion
module gmii_to_rgmii (
	input  logic                   tx_clk,
	input  logic                   rst_n,
	input  marble_pkg::gmii_beat_t tx_beat,
	output marble_pkg::gmii_beat_t rx_beat,
	output logic [3:0]             rgmii_txd,
	output logic                   rgmii_tx_ctl,
	output logic                   rgmii_tx_clk,
	input  logic [3:0]             rgmii_rxd,
	input  logic                   rgmii_rx_ctl
);

	// Transmit beat held for a full period
	logic [7:0] tx_data_q;
	logic       tx_en_q;
	logic       tx_er_q;
	// Receive nibbles, low half from the rising edge
	logic [3:0] rx_lo;
	logic [3:0] rx_hi;
	logic       rx_ctl_lo;
	logic       rx_ctl_hi;
	// Assembled receive beat
	logic [7:0] rx_data_q;
	logic       rx_dv_q;
	logic       rx_er_q;

	always_ff @(posedge tx_clk) begin
		tx_data_q <= tx_beat.data;
		rx_lo <= rgmii_rxd;
		rx_data_q <= {rx_hi, rx_lo};
	end

	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			tx_en_q <= 1'b0;
			tx_er_q <= 1'b0;
			rx_ctl_lo <= 1'b0;
			rx_dv_q <= 1'b0;
			rx_er_q <= 1'b0;
		end else begin
			tx_en_q <= tx_beat.en;
			tx_er_q <= tx_beat.er;
			rx_ctl_lo <= rgmii_rx_ctl;
			// Second half of ctl carries dv xor er
			rx_dv_q <= rx_ctl_lo;
			rx_er_q <= rx_ctl_lo ^ rx_ctl_hi;
		end
	end

	// High nibble and second ctl half
	always_ff @(negedge tx_clk) begin
		rx_hi <= rgmii_rxd;
		if (!rst_n) begin
			rx_ctl_hi <= 1'b0;
		end else begin
			rx_ctl_hi <= rgmii_rx_ctl;
		end
	end

	// Nibble mux on clock level
	assign rgmii_txd = tx_clk ? tx_data_q[3:0] : tx_data_q[7:4];
	assign rgmii_tx_ctl = tx_clk ? tx_en_q : (tx_en_q ^ tx_er_q);
	assign rgmii_tx_clk = tx_clk;

	assign rx_beat = '{data: rx_data_q, en: rx_dv_q, er: rx_er_q};

	// Base never flags an error outside a frame
	tx_er_in_frame: assert property (@(posedge tx_clk) disable iff (!rst_n)
		tx_er_q |-> tx_en_q)
		else $error("tx er raised with en low");

endmodule

/* marble_pkg.sv */
// Marble test build shared types
// Beat, descriptor and configuration definitions
package marble_pkg;

	// Minimum idle beats before an echo starts
	localparam int IFG_CYCLES = 12;
	// Byte FIFO and descriptor FIFO depths
	localparam int DATA_DEPTH = 2048;
	localparam int INFO_DEPTH = 16;
	// Heartbeat tap of the free-running counter
	localparam int HB_BITS = 8;
	// Frame length field width
	localparam int LEN_BITS = 11;

	// Echo on, VCXO on
	localparam logic [3:0] CFG_DEFAULT = 4'b0001;

	// SPI register map
	localparam logic [6:0] REG_EXT_CONFIG = 7'd0;
	localparam logic [6:0] REG_LED_VALUE = 7'd1;
	localparam logic [6:0] REG_LED_OVERRIDE = 7'd2;

	// One GMII byte time, en doubles as dv on receive
	typedef struct packed {
		logic [7:0] data;
		logic       en;
		logic       er;
	} gmii_beat_t;

	// Stored frame descriptor
	typedef struct packed {
		logic [LEN_BITS-1:0] len;
		logic                bad;
	} frame_info_t;

	// Register file contents
	typedef struct packed {
		logic [3:0] ext_config;
		logic [7:0] led_value;
		logic       led_override;
	} cfg_t;

endpackage
